//--- src/rv_core_macros.svh
// Widths and RV32I encodings for the core; only the register and immediate subset is decoded
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

`define RV_XLEN       32
`define RV_NREGS      32
`define RV_REG_AW     5
`define RV_RESET_PC   32'h0000_1000

// Major opcodes
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011

// funct3 codes of the integer group
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL_SRA 3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

`endif

//--- src/rv_core_pkg.sv
// Shared types of the core; widths come from the macro header, which must be on the include path
`include "rv_core_macros.svh"

package rv_core_pkg;

	// ======================================================================
	// Enumerations
	// ======================================================================

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {
		OPA_RS1,
		OPA_PC,
		OPA_ZERO
	} opa_src_e;

	typedef enum logic {
		OPB_RS2,
		OPB_IMM
	} opb_src_e;

	// ======================================================================
	// Stage records
	// ======================================================================

	// Decode to execute
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic [`RV_REG_AW-1:0] rd;
		logic [`RV_REG_AW-1:0] rs1;
		logic [`RV_REG_AW-1:0] rs2;
		alu_op_e               alu_op;
		opa_src_e              opa_src;
		opb_src_e              opb_src;
		logic [`RV_XLEN-1:0]   imm;
		logic [`RV_XLEN-1:0]   pc;
	} decode_t;

	// Execute result, also the register file write port
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic [`RV_REG_AW-1:0] rd;
		logic [`RV_XLEN-1:0]   data;
	} wb_t;

endpackage

//--- src/rv_decoder.sv
// Takes one word per valid cycle without back-pressure; only LUI, AUIPC, OP-IMM and OP are legal
`include "rv_core_macros.svh"

module rv_decoder import rv_core_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid_i,
	input  logic [`RV_XLEN-1:0] instr_i,
	output decode_t             dx_ctrl_o
);

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic                f7_base;
	logic                f7_alt;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] pc_q;
	logic                legal;
	decode_t             dx_d;

	assign opcode  = instr_i[6:0];
	assign funct3  = instr_i[14:12];
	assign funct7  = instr_i[31:25];
	assign f7_base = (funct7 == `RV_F7_BASE);
	assign f7_alt  = (funct7 == `RV_F7_ALT);

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u = {instr_i[31:12], 12'h000};

	always_comb begin
		dx_d         = '0;
		dx_d.rd      = instr_i[11:7];
		dx_d.rs1     = instr_i[19:15];
		dx_d.rs2     = instr_i[24:20];
		dx_d.pc      = pc_q;
		dx_d.alu_op  = ALU_ADD;
		dx_d.opa_src = OPA_RS1;
		dx_d.opb_src = OPB_IMM;
		dx_d.imm     = imm_i;
		legal        = 1'b0;

		case (opcode)
			`RV_OPC_LUI, `RV_OPC_AUIPC: begin
				legal        = 1'b1;
				dx_d.imm     = imm_u;
				dx_d.opa_src = (opcode == `RV_OPC_LUI) ? OPA_ZERO : OPA_PC;
			end
			`RV_OPC_OP_IMM, `RV_OPC_OP: begin
				if (opcode == `RV_OPC_OP) begin
					dx_d.opb_src = OPB_RS2;
				end
				// funct7 only matters for register forms and shifts
				case (funct3)
					`RV_F3_ADD_SUB: begin
						dx_d.alu_op = (opcode == `RV_OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
						legal = (opcode == `RV_OPC_OP_IMM) || f7_base || f7_alt;
					end
					`RV_F3_SLL: begin
						dx_d.alu_op = ALU_SLL;
						legal = f7_base;
					end
					`RV_F3_SRL_SRA: begin
						dx_d.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
						legal = f7_base || f7_alt;
					end
					`RV_F3_SLT:  dx_d.alu_op = ALU_SLT;
					`RV_F3_SLTU: dx_d.alu_op = ALU_SLTU;
					`RV_F3_XOR:  dx_d.alu_op = ALU_XOR;
					`RV_F3_OR:   dx_d.alu_op = ALU_OR;
					default:     dx_d.alu_op = ALU_AND;
				endcase
				if (funct3 == `RV_F3_SLT || funct3 == `RV_F3_SLTU || funct3 == `RV_F3_XOR ||
					funct3 == `RV_F3_OR || funct3 == `RV_F3_AND) begin
					legal = (opcode == `RV_OPC_OP_IMM) || f7_base;
				end
			end
			default: legal = 1'b0;
		endcase

		dx_d.valid   = instr_valid_i && legal;
		dx_d.illegal = instr_valid_i && !legal;
	end

	// PC counts every accepted word whether legal or not
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q      <= `RV_RESET_PC;
			dx_ctrl_o <= '0;
		end else begin
			dx_ctrl_o <= dx_d;
			if (instr_valid_i) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

endmodule

//--- src/rv_regfile.sv
// Registered reads with no internal write-to-read bypass; a read at a write edge sees the old value
`include "rv_core_macros.svh"

module rv_regfile import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`RV_REG_AW-1:0] raddr1_i,
	input  logic [`RV_REG_AW-1:0] raddr2_i,
	output logic [`RV_XLEN-1:0]   rdata1_o,
	output logic [`RV_XLEN-1:0]   rdata2_o,
	input  wb_t                   wb_i
);

	// x0 has no storage
	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
			rdata1_o <= '0;
			rdata2_o <= '0;
		end else begin
			if (wb_i.valid && wb_i.rd != '0) begin
				regs[wb_i.rd] <= wb_i.data;
			end
			rdata1_o <= (raddr1_i == '0) ? '0 : regs[raddr1_i];
			rdata2_o <= (raddr2_i == '0) ? '0 : regs[raddr2_i];
		end
	end

endmodule

//--- src/rv_alu.sv
// Purely combinational; shifts use only the low five bits of operand b
`include "rv_core_macros.svh"

module rv_alu import rv_core_pkg::*; (
	input  alu_op_e             alu_op_i,
	input  logic [`RV_XLEN-1:0] op_a_i,
	input  logic [`RV_XLEN-1:0] op_b_i,
	output logic [`RV_XLEN-1:0] result_o
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = op_b_i[4:0];
	assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
	assign lt_unsigned = op_a_i < op_b_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:  result_o = op_a_i + op_b_i;
			ALU_SUB:  result_o = op_a_i - op_b_i;
			ALU_SLL:  result_o = op_a_i << shamt;
			ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:  result_o = op_a_i ^ op_b_i;
			ALU_SRL:  result_o = op_a_i >> shamt;
			// Arithmetic shift keeps the sign
			ALU_SRA:  result_o = $unsigned($signed(op_a_i) >>> shamt);
			ALU_OR:   result_o = op_a_i | op_b_i;
			ALU_AND:  result_o = op_a_i & op_b_i;
			default:  result_o = '0;
		endcase
	end

endmodule

//--- src/rv_execute.sv
// One-cycle execute; the two youngest results are forwarded so dependants never wait
`include "rv_core_macros.svh"

module rv_execute import rv_core_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  decode_t             dx_ctrl_i,
	input  logic [`RV_XLEN-1:0] rdata1_i,
	input  logic [`RV_XLEN-1:0] rdata2_i,
	output wb_t                 wb_o
);

	wb_t                 wb_q;
	// Copy of the result that was written to the register file at the read edge
	wb_t                 retired_q;
	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_result;

	function automatic logic [`RV_XLEN-1:0] bypass(
		input logic [`RV_REG_AW-1:0] rs,
		input logic [`RV_XLEN-1:0]   rf_data,
		input wb_t                   young,
		input wb_t                   old
	);
		if (rs == '0) begin
			return '0;
		end else if (young.valid && young.rd == rs) begin
			return young.data;
		end else if (old.valid && old.rd == rs) begin
			return old.data;
		end
		return rf_data;
	endfunction

	assign rs1_val = bypass(dx_ctrl_i.rs1, rdata1_i, wb_q, retired_q);
	assign rs2_val = bypass(dx_ctrl_i.rs2, rdata2_i, wb_q, retired_q);

	// ======================================================================
	// Operand select and ALU
	// ======================================================================

	always_comb begin
		case (dx_ctrl_i.opa_src)
			OPA_RS1: op_a = rs1_val;
			OPA_PC:  op_a = dx_ctrl_i.pc;
			default: op_a = '0;
		endcase
		op_b = (dx_ctrl_i.opb_src == OPB_IMM) ? dx_ctrl_i.imm : rs2_val;
	end

	rv_alu u_alu (
		.alu_op_i (dx_ctrl_i.alu_op),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.result_o (alu_result)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_q      <= '0;
			retired_q <= '0;
		end else begin
			wb_q.valid   <= dx_ctrl_i.valid;
			wb_q.illegal <= dx_ctrl_i.illegal;
			wb_q.rd      <= dx_ctrl_i.rd;
			wb_q.data    <= alu_result;
			retired_q    <= wb_q;
		end
	end

	assign wb_o = wb_q;

endmodule

//--- src/rv_core_top.sv
// Results leave in issue order two edges after accept; illegal words retire with no write
`include "rv_core_macros.svh"

module rv_core_top import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid_i,
	input  logic [`RV_XLEN-1:0]   instr_i,
	output logic                  wb_valid_o,
	output logic [`RV_REG_AW-1:0] wb_rd_o,
	output logic [`RV_XLEN-1:0]   wb_data_o,
	output logic                  illegal_o
);

	decode_t             dx_ctrl;
	wb_t                 wb;
	logic [`RV_XLEN-1:0] rdata1;
	logic [`RV_XLEN-1:0] rdata2;

	rv_decoder u_decoder (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.dx_ctrl_o     (dx_ctrl)
	);

	// Read addresses come straight from the raw word, in step with decode
	rv_regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.raddr1_i (instr_i[19:15]),
		.raddr2_i (instr_i[24:20]),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wb_i     (wb)
	);

	rv_execute u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.dx_ctrl_i (dx_ctrl),
		.rdata1_i  (rdata1),
		.rdata2_i  (rdata2),
		.wb_o      (wb)
	);

	assign wb_valid_o = wb.valid;
	assign wb_rd_o    = wb.rd;
	assign wb_data_o  = wb.data;
	assign illegal_o  = wb.illegal;

endmodule

//--- verif/tb_rv_core.sv
// Run from the project root so the hex path resolves; NUM_TESTS must match the data lines
`include "rv_core_macros.svh"

module tb_rv_core;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS  = 28;
	localparam int MEM_WORDS  = 4 * NUM_TESTS;
	localparam int MEM_AW     = $clog2(MEM_WORDS);

	logic                  clk;
	logic                  rst_n;
	logic                  instr_valid_i;
	logic [`RV_XLEN-1:0]   instr_i;
	logic                  wb_valid_o;
	logic [`RV_REG_AW-1:0] wb_rd_o;
	logic [`RV_XLEN-1:0]   wb_data_o;
	logic                  illegal_o;

	// Each test takes four words for instruction, illegal flag, rd and data
	logic [31:0] test_mem [0:MEM_WORDS-1];
	int          pending_q[$];
	int          accept_q[$];
	int          edge_count = 0;
	logic [31:0] lcg_state;

	rv_core_top u_rv_core_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_valid_o    (wb_valid_o),
		.wb_rd_o       (wb_rd_o),
		.wb_data_o     (wb_data_o),
		.illegal_o     (illegal_o)
	);

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] test_field(input int idx, input int col);
		logic [MEM_AW-1:0] addr;
		addr = MEM_AW'(4 * idx + col);
		return test_mem[addr];
	endfunction

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// ======================================================================
	// Clock, stimulus and watchdog
	// ======================================================================

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		int gap;
		rst_n         = 1'b0;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		lcg_state     = 32'h6f2f_0285;
		$readmemh("verif/rv_core_tests.hex", test_mem);
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < NUM_TESTS; i++) begin
			lcg_state = lcg_next(lcg_state);
			gap = int'((lcg_state >> 16) % 32'd3);
			repeat (gap) @(negedge clk);
			instr_valid_i = 1'b1;
			instr_i       = test_field(i, 0);
			pending_q.push_back(i);
			// Accepted at the next rising edge
			accept_q.push_back(edge_count + 1);
			@(negedge clk);
			instr_valid_i = 1'b0;
			instr_i       = '0;
		end

		while (pending_q.size() != 0) begin
			@(negedge clk);
		end
		// A few idle cycles so a stray result is still caught
		repeat (4) @(negedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#((NUM_TESTS * 4 + 64) * CLK_PERIOD);
		$display("Watchdog expired with %0d results still outstanding", pending_q.size());
		fail_run();
	end

	// ======================================================================
	// In-order result checker
	// ======================================================================

	always @(posedge clk) begin
		int          idx;
		int          acc_edge;
		logic [31:0] exp_illegal;
		edge_count = edge_count + 1;
		if (wb_valid_o || illegal_o) begin
			if (pending_q.size() == 0) begin
				$display("A result came out with no instruction pending at edge %0d", edge_count);
				fail_run();
			end else begin
				idx         = pending_q.pop_front();
				acc_edge    = accept_q.pop_front();
				exp_illegal = test_field(idx, 1);
				check_value("result latency", edge_count - acc_edge, 32'd2);
				check_value("illegal_o", {31'b0, illegal_o}, exp_illegal);
				check_value("wb_valid_o", {31'b0, wb_valid_o}, {31'b0, ~exp_illegal[0]});
				if (exp_illegal == 32'd0) begin
					check_value("wb_rd_o", {27'b0, wb_rd_o}, test_field(idx, 2));
					check_value("wb_data_o", wb_data_o, test_field(idx, 3));
				end
			end
		end
	end

endmodule

//--- verif/rv_core_tests.hex
// Columns: instruction word, expected illegal flag, expected rd, expected result data
// PC of line n is 0x1000 + 4*n; illegal lines carry zero rd and data, which are not compared
800000B7 0 01 80000000 // lui   x1, 0x80000
FFB00113 0 02 FFFFFFFB // addi  x2, x0, -5
12300193 0 03 00000123 // addi  x3, x0, 0x123
00512213 0 04 00000001 // slti  x4, x2, 5
00513293 0 05 00000000 // sltiu x5, x2, 5
4040D313 0 06 F8000000 // srai  x6, x1, 4
0040D393 0 07 08000000 // srli  x7, x1, 4
FFF1C413 0 08 FFFFFEDC // xori  x8, x3, -1
0F01E493 0 09 000001F3 // ori   x9, x3, 0xf0
7FF47513 0 0A 000006DC // andi  x10, x8, 0x7ff
01419593 0 0B 12300000 // slli  x11, x3, 20
40218633 0 0C 00000128 // sub   x12, x3, x2
009196B3 0 0D 09180000 // sll   x13, x3, x9
40335733 0 0E FF000000 // sra   x14, x6, x3
0030A7B3 0 0F 00000001 // slt   x15, x1, x3
0030B833 0 10 00000000 // sltu  x16, x1, x3
00002183 1 00 00000000 // lw    x3, 0(x0)
000188B3 0 11 00000123 // add   x17, x3, x0
12345917 0 12 12346048 // auipc x18, 0x12345
05518013 0 00 00000178 // addi  x0, x3, 0x55
012009B3 0 13 12346048 // add   x19, x0, x18
00000063 1 00 00000000 // beq   x0, x0, 0
00000073 1 00 00000000 // ecall
41198A33 0 14 12345F25 // sub   x20, x19, x17
001A0A93 0 15 12345F26 // addi  x21, x20, 1
014ACB33 0 16 00000003 // xor   x22, x21, x20
014B7BB3 0 17 00000001 // and   x23, x22, x20
01703C33 0 18 00000001 // sltu  x24, x0, x23

//--- sources.f
+incdir+src
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_execute.sv
src/rv_core_top.sv
verif/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sources.f --top-module tb_rv_core \
	-Mdir obj_dir -o tb_rv_core; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_rv_core 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
